// ==== run.sh ====
#!/usr/bin/env bash
# build and run the P-M control testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_pm \
	-f tb.f --Mdir obj_dir -o tb_pm; then
	echo "build failed"
	exit 1
fi

./obj_dir/tb_pm
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
fi
exit $status

// ==== src/pm_counters.sv ====
// P-M group and step counters
// LG steers multi-register transfers, LK counts the steps left,
// lk flag is high while steps remain

`timescale 1ns/10ps
`default_nettype none

module pm_counters (
	input logic __clk,
	input logic reset,
	input logic lg_load,
	input logic lg_dec,
	input logic [pm_pkg::LG_WIDTH-1:0] lg_in,
	input logic lk_load,
	input logic lk_dec,
	input logic [pm_pkg::LK_WIDTH-1:0] lk_in,
	output logic [pm_pkg::LG_WIDTH-1:0] lg,
	output logic lk,
	pm_ctrl_if.dst ctrl
);

	import pm_pkg::*;

	logic clr;
	logic [LG_WIDTH-1:0] lg_next;
	logic [LK_WIDTH-1:0] lk_cnt;
	logic [LK_WIDTH-1:0] lk_next;

	// both counters restart with each new cycle
	assign clr = ctrl.clear_state | ctrl.cycle_start;

	// group counter, saturates at zero
	always_comb begin
		lg_next = lg;
		if (clr) begin
			lg_next = '0;
		end else if (lg_load) begin
			lg_next = lg_in;
		end else if (lg_dec && (lg != '0)) begin
			lg_next = lg - 1'b1;
		end
	end

	// step counter, stops at zero
	always_comb begin
		lk_next = lk_cnt;
		if (clr) begin
			lk_next = '0;
		end else if (lk_load) begin
			lk_next = lk_in;
		end else if (lk_dec && (lk_cnt != '0)) begin
			lk_next = lk_cnt - 1'b1;
		end
	end

	always_ff @(posedge __clk) begin
		if (reset) begin
			lg <= '0;
			lk_cnt <= '0;
			lk <= 1'b0;
		end else begin
			lg <= lg_next;
			lk_cnt <= lk_next;
			// flag tracks the new count
			lk <= |lk_next;
		end
	end

endmodule

`default_nettype wire

// ==== src/pm_ctrl_if.sv ====
// P-M cycle status bundle
// carries run, fetch/interrupt flags and the cycle start pulses
// from the cycle controller to the counters and register selector

`timescale 1ns/10ps
`default_nettype none

interface pm_ctrl_if;

	logic run;
	logic fetch;
	logic intr;
	// one clock each, same edge
	logic cycle_start;
	logic clear_state;

	modport src (
		output run,
		output fetch,
		output intr,
		output cycle_start,
		output clear_state
	);

	modport dst (
		input run,
		input fetch,
		input intr,
		input cycle_start,
		input clear_state
	);

endinterface

`default_nettype wire

// ==== src/pm_cycle.sv ====
// P-M run and cycle control
// start/wait flip-flops, branch indicator P, premodification counter,
// cycle-end (KC) and cycle-start (PC) one-shots and the choice
// between instruction fetch and interrupt accept

`timescale 1ns/10ps
`default_nettype none

module pm_cycle #(
	parameter int KC_TICKS = 7,
	parameter int PC_TICKS = 6
) (
	input logic __clk,
	input logic reset,
	input logic start_req,
	input logic stop,
	input logic clo,
	input logic hlt,
	input logic wx,
	input logic irq,
	input logic end_cycle,
	input logic set_p,
	input logic clr_p,
	input logic mc_inc,
	output logic start,
	output logic wait_st,
	output logic p,
	output logic mc_zero,
	output logic mc_full,
	output logic sp0,
	output logic si1,
	pm_ctrl_if.src ctrl
);

	import pm_pkg::*;

	logic [MC_WIDTH-1:0] mc;
	logic kc_q;
	logic kc_done;
	logic pc_q;
	logic pc_done;
	logic kc_trig;
	logic take_intr;
	logic fetch_q;
	logic intr_q;
	logic cyc_pulse;

	// start and wait
	always_ff @(posedge __clk) begin
		if (reset) begin
			start <= 1'b0;
			wait_st <= 1'b0;
		end else if (stop || clo) begin
			start <= 1'b0;
			wait_st <= 1'b0;
		end else begin
			if (start_req) begin
				start <= 1'b1;
			end
			if (hlt && wx) begin
				wait_st <= 1'b1;
			end else if (si1) begin
				// taking an interrupt wakes the processor up
				wait_st <= 1'b0;
			end
		end
	end

	assign ctrl.run = start & ~wait_st;

	// end_cycle is ignored while either one-shot is running
	assign kc_trig = end_cycle & ctrl.run & ~(kc_q | pc_q);

	univib #(
		.TICKS(KC_TICKS)
	) u_kc (
		.__clk(__clk),
		.reset(reset),
		.trig(kc_trig),
		.q(kc_q),
		.done(kc_done)
	);

	// PC follows the fall of KC
	univib #(
		.TICKS(PC_TICKS)
	) u_pc (
		.__clk(__clk),
		.reset(reset),
		.trig(kc_done),
		.q(pc_q),
		.done(pc_done)
	);

	assign take_intr = irq & ~p & mc_zero;

	// fetch or interrupt, latched as KC falls
	always_ff @(posedge __clk) begin
		if (reset) begin
			fetch_q <= 1'b0;
			intr_q <= 1'b0;
		end else if (kc_done) begin
			fetch_q <= ~take_intr;
			intr_q <= take_intr;
		end
	end

	assign ctrl.fetch = fetch_q;
	assign ctrl.intr = intr_q;

	// status pulses at the end of PC
	always_ff @(posedge __clk) begin
		if (reset) begin
			sp0 <= 1'b0;
			si1 <= 1'b0;
			cyc_pulse <= 1'b0;
		end else begin
			sp0 <= pc_done & fetch_q;
			si1 <= pc_done & intr_q;
			cyc_pulse <= pc_done;
		end
	end

	assign ctrl.cycle_start = cyc_pulse;
	assign ctrl.clear_state = cyc_pulse;

	// branch indicator
	always_ff @(posedge __clk) begin
		if (reset) begin
			p <= 1'b0;
		end else if (set_p) begin
			p <= 1'b1;
		end else if (clr_p) begin
			p <= 1'b0;
		end
	end

	// premodification counter, wraps
	always_ff @(posedge __clk) begin
		if (reset || ctrl.clear_state) begin
			mc <= '0;
		end else if (mc_inc) begin
			mc <= mc + 1'b1;
		end
	end

	assign mc_zero = (mc == '0);
	assign mc_full = &mc;

endmodule

`default_nettype wire

// ==== src/pm_pkg.sv ====
// P-M microinstruction control
// shared types and widths for the run control, cycle control,
// counters and general register selector

`default_nettype none

package pm_pkg;

	// main sequencer states
	typedef enum logic [2:0] {
		P0 = 3'd0,
		P1 = 3'd1,
		P2 = 3'd2,
		P3 = 3'd3,
		P4 = 3'd4,
		P5 = 3'd5
	} pm_state_t;

	// general register number
	typedef logic [2:0] reg_num_t;

	// group counter
	localparam int LG_WIDTH = 2;

	// step counter
	localparam int LK_WIDTH = 4;

	// premodification counter
	localparam int MC_WIDTH = 2;

endpackage

`default_nettype wire

// ==== src/pm_regsel.sv ====
// P-M general register selector
// picks the register number from the group counter, the
// instruction fields or the panel selector, by main state

`timescale 1ns/10ps
`default_nettype none

module pm_regsel (
	input pm_pkg::pm_state_t state,
	input logic [15:0] ir,
	input pm_pkg::reg_num_t rs,
	input logic [pm_pkg::LG_WIDTH-1:0] lg,
	input logic group_xfer,
	output pm_pkg::reg_num_t rsel,
	pm_ctrl_if.dst ctrl
);

	import pm_pkg::*;

	reg_num_t group_reg;

	// group transfer walks registers from lg, offset by ir bit 0
	assign group_reg = reg_num_t'(lg) + reg_num_t'(ir[0]);

	always_comb begin
		if (group_xfer && ctrl.run) begin
			rsel = group_reg;
		end else if (state == P3) begin
			// A field
			rsel = ir[15:13];
		end else if (state == P4) begin
			// B field
			rsel = ir[12:10];
		end else if ((state == P0) && !ctrl.run) begin
			// panel register switches
			rsel = rs;
		end else begin
			rsel = '0;
		end
	end

endmodule

`default_nettype wire

// ==== src/pm_top.sv ====
// P-M microinstruction control, top level
// cycle controller, counters and register selector joined
// through the cycle status bundle

`timescale 1ns/10ps
`default_nettype none

module pm_top #(
	parameter int KC_TICKS = 7,
	parameter int PC_TICKS = 6
) (
	input logic __clk,
	input logic reset,
	// run and cycle control
	input logic start_req,
	input logic stop,
	input logic clo,
	input logic hlt,
	input logic wx,
	input logic irq,
	input logic end_cycle,
	input logic set_p,
	input logic clr_p,
	input logic mc_inc,
	output logic start,
	output logic wait_st,
	output logic run,
	output logic fetch,
	output logic intr,
	output logic p,
	output logic mc_zero,
	output logic mc_full,
	output logic sp0,
	output logic si1,
	// counters
	input logic lg_load,
	input logic lg_dec,
	input logic [pm_pkg::LG_WIDTH-1:0] lg_in,
	input logic lk_load,
	input logic lk_dec,
	input logic [pm_pkg::LK_WIDTH-1:0] lk_in,
	output logic [pm_pkg::LG_WIDTH-1:0] lg,
	output logic lk,
	// register selection
	input pm_pkg::pm_state_t state,
	input logic [15:0] ir,
	input pm_pkg::reg_num_t rs,
	input logic group_xfer,
	output pm_pkg::reg_num_t rsel
);

	pm_ctrl_if ctrl ();

	pm_cycle #(
		.KC_TICKS(KC_TICKS),
		.PC_TICKS(PC_TICKS)
	) u_cycle (
		.__clk(__clk),
		.reset(reset),
		.start_req(start_req),
		.stop(stop),
		.clo(clo),
		.hlt(hlt),
		.wx(wx),
		.irq(irq),
		.end_cycle(end_cycle),
		.set_p(set_p),
		.clr_p(clr_p),
		.mc_inc(mc_inc),
		.start(start),
		.wait_st(wait_st),
		.p(p),
		.mc_zero(mc_zero),
		.mc_full(mc_full),
		.sp0(sp0),
		.si1(si1),
		.ctrl(ctrl.src)
	);

	pm_counters u_counters (
		.__clk(__clk),
		.reset(reset),
		.lg_load(lg_load),
		.lg_dec(lg_dec),
		.lg_in(lg_in),
		.lk_load(lk_load),
		.lk_dec(lk_dec),
		.lk_in(lk_in),
		.lg(lg),
		.lk(lk),
		.ctrl(ctrl.dst)
	);

	pm_regsel u_regsel (
		.state(state),
		.ir(ir),
		.rs(rs),
		.lg(lg),
		.group_xfer(group_xfer),
		.rsel(rsel),
		.ctrl(ctrl.dst)
	);

	assign run = ctrl.run;
	assign fetch = ctrl.fetch;
	assign intr = ctrl.intr;

endmodule

`default_nettype wire

// ==== src/univib.sv ====
// one-shot (univibrator)
// a trigger while idle gives a pulse TICKS clocks long,
// done marks the last clock of the pulse

`timescale 1ns/10ps
`default_nettype none

module univib #(
	parameter int TICKS = 4
) (
	input logic __clk,
	input logic reset,
	input logic trig,
	output logic q,
	output logic done
);

	localparam int CW = $clog2(TICKS + 1);

	logic [CW-1:0] cnt;

	always_ff @(posedge __clk) begin
		if (reset) begin
			cnt <= '0;
		end else if (cnt != '0) begin
			cnt <= cnt - 1'b1;
		end else if (trig) begin
			cnt <= CW'(TICKS);
		end
	end

	assign q = (cnt != '0);
	// count is about to hit zero
	assign done = (cnt == CW'(1));

endmodule

`default_nettype wire

// ==== tb.f ====
src/pm_pkg.sv
src/pm_ctrl_if.sv
src/univib.sv
src/pm_cycle.sv
src/pm_counters.sv
src/pm_regsel.sv
src/pm_top.sv
tests/pm_assertions.sv
tests/tb_pm.sv

// ==== tests/pm_assertions.sv ====
// P-M control checks
// status pulse exclusivity, fetch/interrupt exclusivity and
// the causes for the lk flag to drop

`timescale 1ns/10ps
`default_nettype none

module pm_assertions (
	input logic __clk,
	input logic reset,
	input logic sp0,
	input logic si1,
	input logic fetch,
	input logic intr,
	input logic lk,
	input logic lk_dec
);

	logic clear_state;

	// clear_state fires on the same edge as the status pulse
	assign clear_state = sp0 | si1;

	sp0_si1_excl: assert property (@(posedge __clk) disable iff (reset)
		!(sp0 && si1))
		else $error("sp0 and si1 high together");

	fetch_intr_excl: assert property (@(posedge __clk) disable iff (reset)
		!(fetch && intr))
		else $error("fetch and intr high together");

	lk_fall_cause: assert property (@(posedge __clk) disable iff (reset)
		$fell(lk) |-> ($past(lk_dec) || $past(clear_state)))
		else $error("lk dropped without lk_dec or clear_state");

endmodule

bind pm_top pm_assertions u_assertions (
	.__clk(__clk),
	.reset(reset),
	.sp0(sp0),
	.si1(si1),
	.fetch(fetch),
	.intr(intr),
	.lk(lk),
	.lk_dec(lk_dec)
);

`default_nettype wire

// ==== tests/pm_stimulus.txt ====
# ctl start_req stop clo hlt wx exp_start exp_wait | cyc irq set_p clr_p mc_incs retrig exp_intr
# cnt lg_load lg_in lg_dec lk_load lk_in lk_dec exp_lg exp_lk | sel state ir rs group_xfer exp_rsel
sel 0 ffff 5 0 5
sel 3 6000 5 0 3
sel 4 1c00 2 0 7
sel 1 ffff 5 0 0
sel 0 0001 6 1 6
ctl 1 0 0 0 0 1 0
sel 0 0000 6 0 0
cnt 1 2 0 1 3 0 2 1
sel 2 0001 0 1 3
sel 3 0000 0 1 2
cnt 0 0 1 0 0 1 1 1
cnt 0 0 1 0 0 1 0 1
cnt 0 0 1 0 0 1 0 0
cnt 0 0 0 0 0 1 0 0
cnt 1 3 1 1 f 1 3 1
cyc 0 0 1 0 0 0
cnt 0 0 0 0 0 0 0 0
cyc 1 0 1 0 0 1
cyc 1 1 0 0 0 0
cyc 1 0 1 1 0 0
cyc 1 0 0 4 0 1
cyc 0 0 0 0 1 0
ctl 0 0 0 1 1 1 1
sel 0 0000 4 1 4
sel 5 ffff 4 0 0
ctl 0 0 0 1 0 1 1
ctl 0 1 0 0 0 0 0
ctl 1 0 0 0 0 1 0
ctl 0 0 1 0 0 0 0
ctl 1 0 0 0 0 1 0
ctl 1 0 0 1 1 1 1
ctl 0 1 0 0 0 0 0

// ==== tests/tb_pm.sv ====
// P-M microinstruction control testbench
// reads operations from the stimulus file, drives pm_top and
// checks run control, cycle timing, counters and register selection

`timescale 1ns/10ps
`default_nettype none

module tb_pm;

	import pm_pkg::*;

	localparam int KC_TICKS = 7;
	localparam int PC_TICKS = 6;

	logic clk;
	logic reset;
	logic start_req;
	logic stop;
	logic clo;
	logic hlt;
	logic wx;
	logic irq;
	logic end_cycle;
	logic set_p;
	logic clr_p;
	logic mc_inc;
	logic start;
	logic wait_st;
	logic run;
	logic fetch;
	logic intr;
	logic p;
	logic mc_zero;
	logic mc_full;
	logic sp0;
	logic si1;
	logic lg_load;
	logic lg_dec;
	logic [LG_WIDTH-1:0] lg_in;
	logic lk_load;
	logic lk_dec;
	logic [LK_WIDTH-1:0] lk_in;
	logic [LG_WIDTH-1:0] lg;
	logic lk;
	pm_state_t state;
	logic [15:0] ir;
	reg_num_t rs;
	logic group_xfer;
	reg_num_t rsel;

	// reference state kept by the testbench
	logic [LG_WIDTH-1:0] lg_m;
	logic [LK_WIDTH-1:0] lk_m;
	logic p_m;

	string lines[$];
	logic [31:0] f [0:7];
	int unsigned cycles;
	int unsigned limit;

	pm_top #(
		.KC_TICKS(KC_TICKS),
		.PC_TICKS(PC_TICKS)
	) i_pm_top (
		.__clk(clk),
		.reset(reset),
		.start_req(start_req),
		.stop(stop),
		.clo(clo),
		.hlt(hlt),
		.wx(wx),
		.irq(irq),
		.end_cycle(end_cycle),
		.set_p(set_p),
		.clr_p(clr_p),
		.mc_inc(mc_inc),
		.start(start),
		.wait_st(wait_st),
		.run(run),
		.fetch(fetch),
		.intr(intr),
		.p(p),
		.mc_zero(mc_zero),
		.mc_full(mc_full),
		.sp0(sp0),
		.si1(si1),
		.lg_load(lg_load),
		.lg_dec(lg_dec),
		.lg_in(lg_in),
		.lk_load(lk_load),
		.lk_dec(lk_dec),
		.lk_in(lk_in),
		.lg(lg),
		.lk(lk),
		.state(state),
		.ir(ir),
		.rs(rs),
		.group_xfer(group_xfer),
		.rsel(rsel)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			fail_run($sformatf("ERROR: %s = 0x%0h, expected 0x%0h", name, got, exp));
		end
	endtask

	// run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if ((limit != 0) && (cycles >= limit)) begin
			fail_run("timeout: the run did not finish within its cycle limit");
		end
	end

	// start_req stop clo hlt wx, then expected start and wait
	task automatic apply_run_control();
		logic exp_run;
		exp_run = f[5][0] & ~f[6][0];
		@(posedge clk);
		start_req <= f[0][0];
		stop <= f[1][0];
		clo <= f[2][0];
		hlt <= f[3][0];
		wx <= f[4][0];
		@(posedge clk);
		start_req <= 1'b0;
		stop <= 1'b0;
		clo <= 1'b0;
		hlt <= 1'b0;
		wx <= 1'b0;
		@(negedge clk);
		check_value("start", 32'(start), f[5]);
		check_value("wait_st", 32'(wait_st), f[6]);
		check_value("run", 32'(run), 32'(exp_run));
	endtask

	// irq set_p clr_p mc_incs retrig, then expected interrupt
	task automatic apply_cycle();
		int n;
		int quiet;
		logic got;
		logic is_intr;
		logic [MC_WIDTH-1:0] mc_m;
		n = 0;
		got = 1'b0;
		is_intr = f[5][0];
		mc_m = '0;
		@(posedge clk);
		irq <= f[0][0];
		set_p <= f[1][0];
		clr_p <= f[2][0];
		if (f[1][0]) begin
			p_m = 1'b1;
		end else if (f[2][0]) begin
			p_m = 1'b0;
		end
		@(posedge clk);
		set_p <= 1'b0;
		clr_p <= 1'b0;
		mc_inc <= (f[3] != 0);
		for (int i = 0; i < int'(f[3]); i++) begin
			@(posedge clk);
			if (i == int'(f[3]) - 1) begin
				mc_inc <= 1'b0;
			end
			mc_m = mc_m + 1'b1;
			@(negedge clk);
			check_value("mc_zero", 32'(mc_zero), 32'(mc_m == '0));
			check_value("mc_full", 32'(mc_full), 32'(mc_m == {MC_WIDTH{1'b1}}));
		end
		@(negedge clk);
		check_value("p", 32'(p), 32'(p_m));
		check_value("mc_zero", 32'(mc_zero), 32'(mc_m == '0));
		check_value("mc_full", 32'(mc_full), 32'(mc_m == {MC_WIDTH{1'b1}}));
		@(posedge clk);
		end_cycle <= 1'b1;
		while (!got) begin
			@(posedge clk);
			// a second end_cycle during KC or PC must be ignored
			end_cycle <= (f[4] != 0) && ((n == 2) || (n == KC_TICKS + 2));
			n++;
			@(negedge clk);
			got = sp0 | si1;
		end
		check_value("cycle length", 32'(n), 32'(KC_TICKS + PC_TICKS + 1));
		check_value("sp0", 32'(sp0), 32'(!is_intr));
		check_value("si1", 32'(si1), 32'(is_intr));
		check_value("fetch", 32'(fetch), 32'(!is_intr));
		check_value("intr", 32'(intr), 32'(is_intr));
		// an ignored end_cycle must not start a further cycle
		quiet = (f[4] != 0) ? (KC_TICKS + PC_TICKS + 1) : 1;
		repeat (quiet) begin
			@(posedge clk);
			@(negedge clk);
			check_value("sp0", 32'(sp0), 32'd0);
			check_value("si1", 32'(si1), 32'd0);
		end
		// cycle start clears both counters
		lg_m = '0;
		lk_m = '0;
	endtask

	// lg_load lg_in lg_dec lk_load lk_in lk_dec, then expected lg and lk
	task automatic apply_counters();
		@(posedge clk);
		lg_load <= f[0][0];
		lg_in <= f[1][LG_WIDTH-1:0];
		lg_dec <= f[2][0];
		lk_load <= f[3][0];
		lk_in <= f[4][LK_WIDTH-1:0];
		lk_dec <= f[5][0];
		if (f[0][0]) begin
			lg_m = f[1][LG_WIDTH-1:0];
		end else if (f[2][0] && (lg_m != '0)) begin
			lg_m = lg_m - 1'b1;
		end
		if (f[3][0]) begin
			lk_m = f[4][LK_WIDTH-1:0];
		end else if (f[5][0] && (lk_m != '0)) begin
			lk_m = lk_m - 1'b1;
		end
		assert ((32'(lg_m) == f[6]) && (32'(lk_m != '0) == f[7])) else begin
			fail_run("stimulus file expectation disagrees with the counter model");
		end
		@(posedge clk);
		lg_load <= 1'b0;
		lg_dec <= 1'b0;
		lk_load <= 1'b0;
		lk_dec <= 1'b0;
		@(negedge clk);
		check_value("lg", 32'(lg), 32'(lg_m));
		check_value("lk", 32'(lk), 32'(lk_m != '0));
	endtask

	// state ir rs group_xfer, then expected rsel
	task automatic apply_select();
		@(posedge clk);
		state <= pm_state_t'(f[0][2:0]);
		ir <= f[1][15:0];
		rs <= f[2][2:0];
		group_xfer <= f[3][0];
		@(negedge clk);
		check_value("rsel", 32'(rsel), f[4]);
	endtask

	initial begin
		int fd;
		int code;
		string line;
		string op;
		reset = 1'b1;
		{start_req, stop, clo, hlt, wx, irq} = '0;
		{end_cycle, set_p, clr_p, mc_inc} = '0;
		{lg_load, lg_dec, lk_load, lk_dec, group_xfer} = '0;
		lg_in = '0;
		lk_in = '0;
		state = P0;
		ir = '0;
		rs = '0;
		lg_m = '0;
		lk_m = '0;
		p_m = 1'b0;
		limit = 0;
		void'($urandom(32'hafd7));
		fd = $fopen("tests/pm_stimulus.txt", "r");
		if (fd == 0) begin
			fail_run("cannot open the stimulus file tests/pm_stimulus.txt");
		end
		while (!$feof(fd)) begin
			line = "";
			code = $fgets(line, fd);
			if ((code > 0) && (line.len() > 1) && (line[0] != "#")) begin
				lines.push_back(line);
			end
		end
		$fclose(fd);
		limit = lines.size() * (KC_TICKS + PC_TICKS + 8) + 10;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		foreach (lines[k]) begin
			for (int j = 0; j < 8; j++) begin
				f[j] = '0;
			end
			code = $sscanf(lines[k], "%s %h %h %h %h %h %h %h %h", op,
				f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
			if (op == "ctl") begin
				apply_run_control();
			end else if (op == "cyc") begin
				apply_cycle();
			end else if (op == "cnt") begin
				apply_counters();
			end else if (op == "sel") begin
				apply_select();
			end else begin
				fail_run($sformatf("unknown operation '%s' in the stimulus file", op));
			end
			repeat ($urandom % 4) @(posedge clk);
		end
		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire
